//--- common/engine_pkg.sv
package engine_pkg;

   localparam int data_w  = 32;
   localparam int n_slots = 4;
   localparam int n_alu   = 2;
   localparam int slot_w  = $clog2(n_slots);

   typedef logic [data_w-1:0] word_t;

   typedef struct packed {
      word_t slot3;
      word_t slot2;
      word_t slot1;
      word_t slot0;
   } bus_t;

   // Bit 3 set means no operand, bit 2 picks the previous bus
   typedef logic [3:0] sel_t;

   localparam sel_t sel_off = sel_t'(8);

   typedef enum logic [2:0] {
      fn_add,
      fn_sub,
      fn_cmp_sig,
      fn_mux,
      fn_max,
      fn_min,
      fn_or,
      fn_and
   } alu_fn_t;

   typedef struct packed {
      sel_t    sel_a;
      sel_t    sel_b;
      logic    self_loop;
      alu_fn_t fn;
   } alulite_conf_t;

   localparam alulite_conf_t conf_off = '{
      sel_a:     sel_off,
      sel_b:     sel_off,
      self_loop: 1'b0,
      fn:        fn_add
   };

   // Handed from the operand stage to the execute stage
   typedef struct packed {
      word_t   op_a;
      word_t   op_b;
      logic    enabled;
      logic    rst_q;
      alu_fn_t fn;
      logic    self_loop;
   } operands_t;

endpackage

//--- src/operand_mux.sv
`timescale 1ns/1ps

module operand_mux (
   input  engine_pkg::sel_t  sel,
   input  engine_pkg::bus_t  bus,
   input  engine_pkg::bus_t  bus_prev,
   output engine_pkg::word_t data_out,
   output logic              enabled
);

   engine_pkg::word_t [engine_pkg::n_slots-1:0] cur_words;
   engine_pkg::word_t [engine_pkg::n_slots-1:0] prev_words;
   logic [engine_pkg::slot_w-1:0]              slot;
   logic                                       use_prev;

   // Slot 0 is the low word of the bus
   assign cur_words  = bus;
   assign prev_words = bus_prev;

   assign slot     = sel[engine_pkg::slot_w-1:0];
   assign use_prev = sel[engine_pkg::slot_w];
   assign enabled  = (sel < engine_pkg::sel_off);

   always_comb begin
      if (!enabled)
         data_out = '0;
      else if (use_prev)
         data_out = prev_words[slot];
      else
         data_out = cur_words[slot];
   end

endmodule

//--- src/bus_stage.sv
`timescale 1ns/1ps

module bus_stage (
   input  logic                                     clk,
   input  logic                                     rst_int,
   input  engine_pkg::word_t                        in_a,
   input  engine_pkg::word_t                        in_b,
   input  engine_pkg::word_t [engine_pkg::n_alu-1:0] results_in,
   output engine_pkg::bus_t                         bus_in,
   output engine_pkg::bus_t                         bus_prev
);

   engine_pkg::word_t slot0_q;
   engine_pkg::word_t slot1_q;
   engine_pkg::bus_t  bus_full;

   // ALU slots are filled in by the top level
   assign bus_in = '{slot3: '0, slot2: '0, slot1: slot1_q, slot0: slot0_q};

   assign bus_full = '{
      slot3: results_in[1],
      slot2: results_in[0],
      slot1: slot1_q,
      slot0: slot0_q
   };

   always_ff @(posedge clk) begin
      if (rst_int) begin
         slot0_q  <= '0;
         slot1_q  <= '0;
         bus_prev <= '0;
      end else begin
         slot0_q  <= in_a;
         slot1_q  <= in_b;
         bus_prev <= bus_full;   // Whole bus one cycle late
      end
   end

endmodule

//--- src/conf_bank.sv
`timescale 1ns/1ps

module conf_bank (
   input  logic                      clk,
   input  logic                      rst_int,
   input  logic                      cfg_we,
   input  logic                      cfg_unit,
   input  engine_pkg::alulite_conf_t cfg_data,
   output engine_pkg::alulite_conf_t conf0,
   output engine_pkg::alulite_conf_t conf1
);

   engine_pkg::alulite_conf_t [engine_pkg::n_alu-1:0] conf_q;

   always_ff @(posedge clk) begin
      if (rst_int) begin
         conf_q <= {engine_pkg::n_alu{engine_pkg::conf_off}};   // Both units idle
      end else if (cfg_we) begin
         conf_q[cfg_unit] <= cfg_data;
      end
   end

   assign conf0 = conf_q[0];
   assign conf1 = conf_q[1];

   // A write with an unknown unit would corrupt either bank entry
   a_unit_known: assert property (
      @(posedge clk) disable iff (rst_int)
      cfg_we |-> !$isunknown(cfg_unit)
   ) else $error("conf_bank: cfg_unit unknown on write");

endmodule

//--- alulite/alulite_operands.sv
`timescale 1ns/1ps

module alulite_operands (
   input  logic                      clk,
   input  logic                      rst_int,
   input  engine_pkg::alulite_conf_t conf,
   input  engine_pkg::bus_t          bus,
   input  engine_pkg::bus_t          bus_prev,
   output engine_pkg::operands_t     ops
);

   engine_pkg::word_t op_a;
   engine_pkg::word_t op_b;
   logic              enable_a;
   logic              enable_b;

   operand_mux mux_a (
      .sel      (conf.sel_a),
      .bus      (bus),
      .bus_prev (bus_prev),
      .data_out (op_a),
      .enabled  (enable_a)
   );

   operand_mux mux_b (
      .sel      (conf.sel_b),
      .bus      (bus),
      .bus_prev (bus_prev),
      .data_out (op_b),
      .enabled  (enable_b)
   );

   always_ff @(posedge clk) begin
      ops.rst_q     <= rst_int;   // Reset follows the data into exec
      ops.fn        <= conf.fn;
      ops.self_loop <= conf.self_loop;
      if (rst_int) begin
         ops.op_a    <= '0;
         ops.op_b    <= '0;
         ops.enabled <= 1'b0;
      end else begin
         ops.op_a    <= op_a;
         ops.op_b    <= op_b;
         ops.enabled <= enable_a & enable_b;
      end
   end

endmodule

//--- alulite/alulite_exec.sv
`timescale 1ns/1ps

module alulite_exec (
   input  logic                  clk,
   input  engine_pkg::operands_t ops,
   output engine_pkg::word_t     result
);

   localparam int msb = engine_pkg::data_w - 1;

   engine_pkg::word_t           a_int;
   engine_pkg::word_t           result_next;
   logic                        invert_a;
   logic                        sign_ext;
   logic                        b_lt_a;
   logic                        flag;
   logic [engine_pkg::data_w:0] a_ext;
   logic [engine_pkg::data_w:0] b_ext;
   logic [engine_pkg::data_w:0] sum;

   assign a_int = ops.self_loop ? result : ops.op_a;
   assign flag  = ops.op_a[msb];   // Restart or hold under self-loop

   always_comb begin
      invert_a = 1'b0;
      sign_ext = 1'b0;
      case (ops.fn)
         engine_pkg::fn_sub: begin
            invert_a = 1'b1;
         end
         engine_pkg::fn_cmp_sig, engine_pkg::fn_max, engine_pkg::fn_min: begin
            invert_a = 1'b1;
            sign_ext = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // Single 33-bit adder, B - A when invert_a is set
   assign a_ext  = {sign_ext & a_int[msb], a_int};
   assign b_ext  = {sign_ext & ops.op_b[msb], ops.op_b};
   assign sum    = b_ext + (invert_a ? ~a_ext : a_ext) + {{engine_pkg::data_w{1'b0}}, invert_a};
   assign b_lt_a = sum[engine_pkg::data_w];

   always_comb begin
      result_next = sum[msb:0];
      case (ops.fn)
         engine_pkg::fn_add: begin
            if (ops.self_loop && flag)
               result_next = ops.op_b;
         end
         engine_pkg::fn_cmp_sig: begin
            result_next[msb] = b_lt_a;
         end
         engine_pkg::fn_mux: begin
            if (flag)
               result_next = ops.op_b;
            else if (ops.self_loop)
               result_next = result;
            else
               result_next = '0;
         end
         engine_pkg::fn_max: begin
            result_next = b_lt_a ? a_int : ops.op_b;
            if (ops.self_loop && flag)
               result_next = result;
         end
         engine_pkg::fn_min: begin
            result_next = b_lt_a ? ops.op_b : a_int;
            if (ops.self_loop && flag)
               result_next = result;
         end
         engine_pkg::fn_or: begin
            result_next = a_int | ops.op_b;
         end
         engine_pkg::fn_and: begin
            result_next = a_int & ops.op_b;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (ops.rst_q)
         result <= '0;
      else if (ops.enabled)
         result <= result_next;
   end

   a_hold_disabled: assert property (
      @(posedge clk) disable iff (ops.rst_q)
      !ops.enabled |=> $stable(result)
   ) else $error("alulite_exec: result moved after a disabled pair");

endmodule

//--- src/data_engine.sv
`timescale 1ns/1ps

module data_engine (
   input  logic                                     clk,
   input  logic                                     rst_int,
   input  engine_pkg::word_t                        in_a,
   input  engine_pkg::word_t                        in_b,
   input  logic                                     cfg_we,
   input  logic                                     cfg_unit,
   input  engine_pkg::alulite_conf_t                cfg_data,
   output engine_pkg::word_t [engine_pkg::n_alu-1:0] results
);

   engine_pkg::bus_t          bus_in;
   engine_pkg::bus_t          bus;
   engine_pkg::bus_t          bus_prev;
   engine_pkg::alulite_conf_t conf0;
   engine_pkg::alulite_conf_t conf1;
   engine_pkg::operands_t     ops0;
   engine_pkg::operands_t     ops1;

   // Input slots from the bus stage, ALU results on slots 2 and 3
   assign bus = '{
      slot3: results[1],
      slot2: results[0],
      slot1: bus_in.slot1,
      slot0: bus_in.slot0
   };

   bus_stage u_bus (
      .clk        (clk),
      .rst_int    (rst_int),
      .in_a       (in_a),
      .in_b       (in_b),
      .results_in (results),
      .bus_in     (bus_in),
      .bus_prev   (bus_prev)
   );

   conf_bank u_conf (
      .clk      (clk),
      .rst_int  (rst_int),
      .cfg_we   (cfg_we),
      .cfg_unit (cfg_unit),
      .cfg_data (cfg_data),
      .conf0    (conf0),
      .conf1    (conf1)
   );

   alulite_operands u_ops0 (
      .clk      (clk),
      .rst_int  (rst_int),
      .conf     (conf0),
      .bus      (bus),
      .bus_prev (bus_prev),
      .ops      (ops0)
   );

   alulite_exec u_exec0 (
      .clk    (clk),
      .ops    (ops0),
      .result (results[0])
   );

   alulite_operands u_ops1 (
      .clk      (clk),
      .rst_int  (rst_int),
      .conf     (conf1),
      .bus      (bus),
      .bus_prev (bus_prev),
      .ops      (ops1)
   );

   alulite_exec u_exec1 (
      .clk    (clk),
      .ops    (ops1),
      .result (results[1])
   );

endmodule

//--- test/engine_vectors.svh
// Columns: cfg write, unit, conf {sel_a, sel_b, self_loop|fn}, random, in_a, in_b,
// result0 and result1 expected three rows later, check mask {result1, result0}
localparam int n_rows = 42;

row_t vectors [n_rows] = '{
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000011, 32'h00000022, 32'h00000000, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000055, 32'h00000066, 32'h00000000, 32'h00000000, 2'b11},
   '{1'b1, 1'b0, 12'h010, 1'b0, 32'h00000005, 32'h00000007, 32'h0000000c, 32'h00000000, 2'b11},
   '{1'b1, 1'b0, 12'h011, 1'b0, 32'h00000003, 32'h0000000a, 32'h00000007, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h0000000a, 32'h00000003, 32'hfffffff9, 32'h00000000, 2'b11},
   '{1'b1, 1'b0, 12'h016, 1'b0, 32'h0000f0f0, 32'h00000ff0, 32'h0000fff0, 32'h00000000, 2'b11},
   '{1'b1, 1'b0, 12'h017, 1'b0, 32'h0000f0f0, 32'h00000ff0, 32'h000000f0, 32'h00000000, 2'b11},
   '{1'b1, 1'b0, 12'h014, 1'b0, 32'hfffffffe, 32'h00000005, 32'h00000005, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h80000000, 32'hffffffff, 32'hffffffff, 32'h00000000, 2'b11},
   '{1'b1, 1'b0, 12'h015, 1'b0, 32'hfffffffe, 32'h00000005, 32'hfffffffe, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h7fffffff, 32'h80000000, 32'h80000000, 32'h00000000, 2'b11},
   '{1'b1, 1'b0, 12'h012, 1'b0, 32'h00000005, 32'h00000003, 32'hfffffffe, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000003, 32'h00000005, 32'h00000002, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h7fffffff, 32'h80000000, 32'h80000001, 32'h00000000, 2'b11},
   '{1'b1, 1'b0, 12'h013, 1'b0, 32'h80000000, 32'h00001234, 32'h00001234, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h7fffffff, 32'h00005678, 32'h00000000, 32'h00000000, 2'b11},
   '{1'b1, 1'b0, 12'h010, 1'b1, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b1, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 2'b11},
   '{1'b1, 1'b0, 12'h014, 1'b1, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b1, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 2'b11},
   // Self-loop add, flag restarts the sum
   '{1'b1, 1'b0, 12'h018, 1'b0, 32'h80000000, 32'h00000005, 32'h00000005, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000000, 32'h00000003, 32'h00000008, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000000, 32'h00000010, 32'h00000018, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h80000000, 32'h00000100, 32'h00000100, 32'h00000000, 2'b11},
   // Running max, flag holds
   '{1'b1, 1'b0, 12'h01c, 1'b0, 32'h00000000, 32'h00000200, 32'h00000200, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h80000000, 32'h00000900, 32'h00000200, 32'h00000000, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000000, 32'h00000300, 32'h00000300, 32'h00000000, 2'b11},
   // Unit 1 follows slot 2, current bus then previous bus
   '{1'b1, 1'b0, 12'h010, 1'b0, 32'h00000001, 32'h00000002, 32'h00000003, 32'h00000000, 2'b11},
   '{1'b1, 1'b1, 12'h226, 1'b0, 32'h00000010, 32'h00000020, 32'h00000030, 32'h00000300, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000100, 32'h00000200, 32'h00000300, 32'h00000003, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00001000, 32'h00000001, 32'h00001001, 32'h00000030, 2'b11},
   '{1'b1, 1'b1, 12'h666, 1'b0, 32'h00000007, 32'h00000008, 32'h0000000f, 32'h00000030, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000020, 32'h00000020, 32'h00000040, 32'h00000300, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000001, 32'h00000001, 32'h00000002, 32'h00001001, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000003, 32'h00000004, 32'h00000007, 32'h0000000f, 2'b11},
   '{1'b1, 1'b1, 12'h880, 1'b0, 32'h00000055, 32'h00000066, 32'h000000bb, 32'h0000000f, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000077, 32'h00000088, 32'h000000ff, 32'h0000000f, 2'b11},
   '{1'b1, 1'b0, 12'h880, 1'b0, 32'h00000009, 32'h00000009, 32'h000000ff, 32'h0000000f, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00001234, 32'h00004321, 32'h000000ff, 32'h0000000f, 2'b11},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 2'b00},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 2'b00},
   '{1'b0, 1'b0, 12'h000, 1'b0, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 2'b00}
};

//--- test/data_engine_tb.sv
`timescale 1ns/1ps

module data_engine_tb;

   typedef struct packed {
      logic                      we;
      logic                      unit;
      engine_pkg::alulite_conf_t conf;
      logic                      rnd;
      engine_pkg::word_t         a;
      engine_pkg::word_t         b;
      engine_pkg::word_t         exp0;
      engine_pkg::word_t         exp1;
      logic [1:0]                mask;
   } row_t;

   `include "engine_vectors.svh"

   localparam int latency    = 3;   // Drive edge to visible result
   localparam int timeout_ns = (n_rows + 20) * 4;

   logic                                     clk;
   logic                                     rst_int;
   engine_pkg::word_t                        in_a;
   engine_pkg::word_t                        in_b;
   logic                                     cfg_we;
   logic                                     cfg_unit;
   engine_pkg::alulite_conf_t                cfg_data;
   engine_pkg::word_t [engine_pkg::n_alu-1:0] results;
   integer                                   seed;
   engine_pkg::alu_fn_t                      fn0;

   data_engine uut (
      .clk      (clk),
      .rst_int  (rst_int),
      .in_a     (in_a),
      .in_b     (in_b),
      .cfg_we   (cfg_we),
      .cfg_unit (cfg_unit),
      .cfg_data (cfg_data),
      .results  (results)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Result of one ALU function without self-loop
   function automatic engine_pkg::word_t expect_word(engine_pkg::alu_fn_t fn,
                                                     engine_pkg::word_t a,
                                                     engine_pkg::word_t b);
      engine_pkg::word_t diff;
      diff = b - a;
      case (fn)
         engine_pkg::fn_add:     return a + b;
         engine_pkg::fn_sub:     return diff;
         engine_pkg::fn_cmp_sig: return {($signed(b) < $signed(a)), diff[30:0]};
         engine_pkg::fn_mux:     return a[31] ? b : '0;
         engine_pkg::fn_max:     return ($signed(a) > $signed(b)) ? a : b;
         engine_pkg::fn_min:     return ($signed(a) < $signed(b)) ? a : b;
         engine_pkg::fn_or:      return a | b;
         default:                return a & b;
      endcase
   endfunction

   task automatic check_word(input engine_pkg::word_t got, input engine_pkg::word_t exp,
                             input string what);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("test failed");
         $fatal(1);
      end
   endtask

   initial begin
      #(timeout_ns);
      $display("Simulation timed out before all rows were checked");
      $display("test failed");
      $fatal(1);
   end

   initial begin
      row_t row;
      int   i;
      rst_int  = 1'b1;
      in_a     = '0;
      in_b     = '0;
      cfg_we   = 1'b0;
      cfg_unit = 1'b0;
      cfg_data = engine_pkg::conf_off;
      seed     = 75;
      fn0      = engine_pkg::fn_add;

      // Fill random rows, unit 0 reads slots 0 and 1 there
      for (i = 0; i < n_rows; i++) begin
         if (vectors[i].we && !vectors[i].unit)
            fn0 = vectors[i].conf.fn;
         if (vectors[i].rnd) begin
            vectors[i].a    = $random(seed);
            vectors[i].b    = $random(seed);
            vectors[i].exp0 = expect_word(fn0, vectors[i].a, vectors[i].b);
         end
      end

      repeat (8) @(posedge clk);
      rst_int <= 1'b0;

      for (i = 0; i < n_rows; i++) begin
         @(posedge clk);
         cfg_we   <= vectors[i].we;
         cfg_unit <= vectors[i].unit;
         cfg_data <= vectors[i].conf;
         in_a     <= vectors[i].a;
         in_b     <= vectors[i].b;
         @(negedge clk);
         if (i >= latency) begin
            row = vectors[i - latency];
            if (row.mask[0])
               check_word(results[0], row.exp0, "result0");
            if (row.mask[1])
               check_word(results[1], row.exp1, "result1");
         end
      end

      $display("test passed");
      $finish;
   end

endmodule

//--- list.f
+incdir+test
common/engine_pkg.sv
src/operand_mux.sv
src/bus_stage.sv
src/conf_bank.sv
alulite/alulite_operands.sv
alulite/alulite_exec.sv
src/data_engine.sv
test/data_engine_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f list.f --top-module data_engine_tb -o sim

out=$(./obj_dir/sim)
echo "$out"
echo "$out" | grep -q "^test passed$"
